//--- design/mipsPkg.sv
/*
  shared types for the MIPS-subset pipeline
  opcodes and funct codes follow the standard MIPS32 encodings
*/
`default_nettype none

package mipsPkg;

	// primary opcodes
	localparam logic [5:0] opR    = 6'h00;
	localparam logic [5:0] opJ    = 6'h02;
	localparam logic [5:0] opJal  = 6'h03;
	localparam logic [5:0] opBeq  = 6'h04;
	localparam logic [5:0] opBne  = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw   = 6'h23;
	localparam logic [5:0] opSw   = 6'h2b;

	// R-format funct codes
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	typedef logic [4:0] regIdxT;

	typedef struct packed {
		logic [5:0] op;
		regIdxT     rs;
		regIdxT     rt;
		regIdxT     rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmtT;

	// jumps take rs, rt and imm16 together as the 26-bit target
	typedef struct packed {
		logic [5:0]  op;
		regIdxT      rs;
		regIdxT      rt;
		logic [15:0] imm16;
	} iFmtT;

	// same word, two field layouts
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
	} instrU;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	typedef struct packed {
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrcImm;
		logic  isBranch;
		logic  branchNe;
		logic  jump;
		logic  link;
		aluOpT aluOp;
	} ctlT;

	// one pipeline register, reused for ID/EX, EX/MEM and MEM/WB
	typedef struct packed {
		logic        valid;
		logic [5:0]  op;
		ctlT         ctl;
		regIdxT      rs;
		regIdxT      rt;
		regIdxT      dest;
		logic [31:0] pcPlus4;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [31:0] result;
	} stageT;

	typedef struct packed {
		logic pcWrite;
		logic ifIdWrite;
		logic ifFlush;
		logic bubble;
	} hazCtlT;

endpackage

`default_nettype wire

//--- design/hazardUnit.sv
/*
  purely combinational interlock for the ID stage
  CLK and rst only serve a bound checker, the logic ignores them
  register 0 never creates a dependency
*/
`default_nettype none

module hazardUnit (
	input  wire logic            CLK,
	input  wire logic            rst,
	input  wire mipsPkg::instrU  idInstr,
	input  wire mipsPkg::stageT  exStage,
	input  wire mipsPkg::stageT  memStage,
	input  wire logic            branchTaken,
	input  wire logic            jump,
	output mipsPkg::hazCtlT      hazCtl
);

	logic [5:0]      idOp;
	mipsPkg::regIdxT idRs;
	mipsPkg::regIdxT idRt;
	logic            idBranch;
	logic            idReadsRs;
	logic            idReadsRt;
	logic            exLoad;
	logic            exAluWrite;
	logic            memLoad;
	logic            exHitsId;
	logic            memHitsId;
	logic            exHitsOperand;
	logic            ctlDep1;
	logic            ctlDep2a;
	logic            ctlDep2b;
	logic            loadUse;
	logic            stall;

	assign idOp = idInstr.iFmt.op;
	assign idRs = idInstr.iFmt.rs;
	assign idRt = idInstr.iFmt.rt;

	// branches compare in ID, so they need both sources early
	assign idBranch = (idOp == mipsPkg::opBeq) || (idOp == mipsPkg::opBne);

	// which sources the ID instruction actually reads in EX
	assign idReadsRs = (idOp == mipsPkg::opR) || (idOp == mipsPkg::opAddi) ||
		(idOp == mipsPkg::opLw) || (idOp == mipsPkg::opSw);
	assign idReadsRt = (idOp == mipsPkg::opR) || (idOp == mipsPkg::opSw);

	// producer classification
	assign exLoad     = exStage.valid && (exStage.op == mipsPkg::opLw);
	assign exAluWrite = exStage.valid && exStage.ctl.regWrite && !exLoad;
	assign memLoad    = memStage.valid && (memStage.op == mipsPkg::opLw);

	// dest match against either branch source
	assign exHitsId = (exStage.dest != '0) &&
		((exStage.dest == idRs) || (exStage.dest == idRt));
	assign memHitsId = (memStage.dest != '0) &&
		((memStage.dest == idRs) || (memStage.dest == idRt));

	// match only against operands really read
	assign exHitsOperand = (exStage.dest != '0) &&
		((idReadsRs && (exStage.dest == idRs)) || (idReadsRt && (exStage.dest == idRt)));

	// ALU result one ahead of a branch, one bubble
	assign ctlDep1 = idBranch && exAluWrite && exHitsId;
	// load ahead of a branch, two bubbles over two cycles
	assign ctlDep2a = idBranch && exLoad && exHitsId;
	assign ctlDep2b = idBranch && memLoad && memHitsId;
	// load ahead of an ordinary consumer
	assign loadUse = !idBranch && exLoad && exHitsOperand;

	assign stall = ctlDep1 || ctlDep2a || ctlDep2b || loadUse;

	// a stall holds the branch in ID, so no redirect yet
	always_comb begin
		hazCtl.pcWrite   = !stall;
		hazCtl.ifIdWrite = !stall;
		hazCtl.bubble    = stall;
		hazCtl.ifFlush   = (branchTaken || jump) && !stall;
	end

endmodule

`default_nettype wire

//--- design/instrDecode.sv
/*
  ID-stage decoder for the supported subset only
  unknown opcodes and functs decode as a no-op with dest 0
*/
`default_nettype none

module instrDecode (
	input  wire mipsPkg::instrU instr,
	output mipsPkg::ctlT        ctl,
	output mipsPkg::regIdxT     rs,
	output mipsPkg::regIdxT     rt,
	output mipsPkg::regIdxT     dest,
	output logic [31:0]         imm
);

	assign rs  = instr.iFmt.rs;
	assign rt  = instr.iFmt.rt;
	assign imm = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};

	always_comb begin
		// everything off unless an opcode turns it on
		ctl       = '0;
		ctl.aluOp = mipsPkg::aluAdd;
		dest      = '0;
		case (instr.rFmt.op)
			mipsPkg::opR: begin
				ctl.regWrite = 1'b1;
				dest         = instr.rFmt.rd;
				case (instr.rFmt.funct)
					mipsPkg::fnAdd: ctl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:  ctl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: ctl.aluOp = mipsPkg::aluSlt;
					default: begin
						// includes the all-zero flushed word
						ctl.regWrite = 1'b0;
						dest         = '0;
					end
				endcase
			end
			mipsPkg::opAddi: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				dest          = instr.iFmt.rt;
			end
			mipsPkg::opLw: begin
				ctl.regWrite  = 1'b1;
				ctl.memRead   = 1'b1;
				ctl.memToReg  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				dest          = instr.iFmt.rt;
			end
			mipsPkg::opSw: begin
				ctl.memWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
			end
			mipsPkg::opBeq: ctl.isBranch = 1'b1;
			mipsPkg::opBne: begin
				ctl.isBranch = 1'b1;
				ctl.branchNe = 1'b1;
			end
			mipsPkg::opJ: ctl.jump = 1'b1;
			mipsPkg::opJal: begin
				// link register is fixed
				ctl.jump     = 1'b1;
				ctl.link     = 1'b1;
				ctl.regWrite = 1'b1;
				dest         = 5'd31;
			end
			default: ctl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/regFile.sv
/*
  32x32 register file, 2 read ports and 1 write port
  a same-cycle write is visible on the read ports, register 0 reads zero
  reset clears every register
*/
`default_nettype none

module regFile (
	input  wire logic            CLK,
	input  wire logic            rst,
	input  wire mipsPkg::regIdxT rdA,
	input  wire mipsPkg::regIdxT rdB,
	output logic [31:0]          valA,
	output logic [31:0]          valB,
	input  wire logic            we,
	input  wire mipsPkg::regIdxT wIdx,
	input  wire logic [31:0]     wData
);

	logic [31:0] regs [32];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wIdx != '0)) begin
			regs[wIdx] <= wData;
		end
	end

	// WB bypass so ID sees the value retiring this cycle
	assign valA = (rdA == '0) ? 32'd0 :
		(we && (wIdx == rdA)) ? wData : regs[rdA];
	assign valB = (rdB == '0) ? 32'd0 :
		(we && (wIdx == rdB)) ? wData : regs[rdB];

endmodule

`default_nettype wire

//--- design/execUnit.sv
/*
  EX-stage ALU with operand forwarding, MEM has priority over WB
  loads in MEM are never forwarded, the hazard unit stalls those
*/
`default_nettype none

module execUnit (
	input  wire mipsPkg::stageT  exStage,
	input  wire mipsPkg::stageT  memFwd,
	input  wire logic            wbFwdValid,
	input  wire mipsPkg::regIdxT wbFwdReg,
	input  wire logic [31:0]     wbFwdData,
	output logic [31:0]          result,
	output logic [31:0]          storeData
);

	logic        memOk;
	logic        wbOk;
	logic [31:0] opA;
	logic [31:0] rtFwd;
	logic [31:0] opB;
	logic [31:0] aluOut;

	// usable producers, register 0 excluded
	assign memOk = memFwd.valid && memFwd.ctl.regWrite && !memFwd.ctl.memRead &&
		(memFwd.dest != '0);
	assign wbOk = wbFwdValid && (wbFwdReg != '0);

	// newest value wins
	assign opA = (memOk && (memFwd.dest == exStage.rs)) ? memFwd.result :
		(wbOk && (wbFwdReg == exStage.rs)) ? wbFwdData : exStage.rsVal;
	assign rtFwd = (memOk && (memFwd.dest == exStage.rt)) ? memFwd.result :
		(wbOk && (wbFwdReg == exStage.rt)) ? wbFwdData : exStage.rtVal;

	assign opB       = exStage.ctl.aluSrcImm ? exStage.imm : rtFwd;
	assign storeData = rtFwd;

	always_comb begin
		case (exStage.ctl.aluOp)
			mipsPkg::aluSub: aluOut = opA - opB;
			mipsPkg::aluAnd: aluOut = opA & opB;
			mipsPkg::aluOr:  aluOut = opA | opB;
			// signed compare
			mipsPkg::aluSlt: aluOut = {31'd0, $signed(opA) < $signed(opB)};
			default:         aluOut = opA + opB;
		endcase
	end

	// jal writes its return address
	assign result = exStage.ctl.link ? exStage.pcPlus4 : aluOut;

endmodule

`default_nettype wire

//--- design/dataMem.sv
/*
  word-addressed data memory, byte address bits 1:0 are ignored
  address wraps modulo DMEM_WORDS, which must be at least 2
  contents are not cleared by reset
*/
`default_nettype none

module dataMem #(
	parameter int DMEM_WORDS = 256
) (
	input  wire logic        CLK,
	input  wire logic        we,
	input  wire logic [31:0] addr,
	input  wire logic [31:0] wData,
	output logic [31:0]      rData
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [31:0]   mem [DMEM_WORDS];
	logic [AW-1:0] wordIdx;

	// word index with wraparound
	assign wordIdx = AW'(addr[31:2] % DMEM_WORDS);

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[wordIdx] <= wData;
		end
	end

	// asynchronous read for lw in MEM
	assign rData = mem[wordIdx];

endmodule

`default_nettype wire

//--- design/cpuPipe.sv
/*
  five-stage MIPS-subset pipeline, branches resolve in ID, no delay slot
  instruction memory must answer combinationally on imemAddr
  wb and store ports pulse once per retired write or store
*/
`default_nettype none

module cpuPipe #(
	parameter logic [31:0] RESET_PC   = 32'h0,
	parameter int          DMEM_WORDS = 256
) (
	input  wire logic        CLK,
	input  wire logic        rst,
	output logic [31:0]      imemAddr,
	input  wire logic [31:0] imemData,
	output logic             wbValid,
	output mipsPkg::regIdxT  wbReg,
	output logic [31:0]      wbData,
	output logic             stValid,
	output logic [31:0]      stAddr,
	output logic [31:0]      stData
);

	logic [31:0]      pc;
	logic [31:0]      pcPlus4;
	logic [31:0]      pcNext;
	logic             ifIdValid;
	mipsPkg::instrU   ifIdInstr;
	logic [31:0]      ifIdPc4;
	mipsPkg::ctlT     decCtl;
	mipsPkg::ctlT     idCtl;
	mipsPkg::regIdxT  idRs;
	mipsPkg::regIdxT  idRt;
	mipsPkg::regIdxT  idDest;
	logic [31:0]      idImm;
	logic [31:0]      rfA;
	logic [31:0]      rfB;
	logic             memFwdOk;
	logic [31:0]      cmpA;
	logic [31:0]      cmpB;
	logic             branchTaken;
	logic [31:0]      branchTarget;
	logic [31:0]      jumpTarget;
	mipsPkg::hazCtlT  hazCtl;
	mipsPkg::stageT   idNext;
	mipsPkg::stageT   exStage;
	mipsPkg::stageT   memStage;
	mipsPkg::stageT   wbStage;
	logic [31:0]      exResult;
	logic [31:0]      exStoreData;
	logic [31:0]      memRData;
	logic             rfWe;

	// IF
	assign imemAddr = pc;
	assign pcPlus4  = pc + 32'd4;

	// redirect only when the hazard unit lets the flush through
	assign pcNext = !hazCtl.ifFlush ? pcPlus4 :
		idCtl.jump ? jumpTarget : branchTarget;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (hazCtl.pcWrite) begin
			pc <= pcNext;
		end
	end

	// IF/ID, a flush leaves an all-zero word which decodes as a no-op
	always_ff @(posedge CLK) begin
		if (rst || hazCtl.ifFlush) begin
			ifIdValid <= 1'b0;
			ifIdInstr <= '0;
		end else if (hazCtl.ifIdWrite) begin
			ifIdValid <= 1'b1;
			ifIdInstr <= imemData;
			ifIdPc4   <= pcPlus4;
		end
	end

	// ID
	instrDecode uDecode (
		.instr (ifIdInstr),
		.ctl   (decCtl),
		.rs    (idRs),
		.rt    (idRt),
		.dest  (idDest),
		.imm   (idImm)
	);

	assign idCtl = ifIdValid ? decCtl : '0;

	regFile uRegs (
		.CLK   (CLK),
		.rst   (rst),
		.rdA   (idRs),
		.rdB   (idRt),
		.valA  (rfA),
		.valB  (rfB),
		.we    (rfWe),
		.wIdx  (wbStage.dest),
		.wData (wbStage.result)
	);

	// comparator forwarding from EX/MEM only
	// EX producers and loads are covered by stalls instead
	assign memFwdOk = memStage.valid && memStage.ctl.regWrite &&
		!memStage.ctl.memRead && (memStage.dest != '0);
	assign cmpA = (memFwdOk && (memStage.dest == idRs)) ? memStage.result : rfA;
	assign cmpB = (memFwdOk && (memStage.dest == idRt)) ? memStage.result : rfB;

	assign branchTaken  = idCtl.isBranch && ((cmpA == cmpB) != idCtl.branchNe);
	assign branchTarget = ifIdPc4 + {idImm[29:0], 2'b00};
	// 26-bit target spans rs, rt and imm16
	assign jumpTarget = {ifIdPc4[31:28], ifIdInstr.iFmt.rs, ifIdInstr.iFmt.rt,
		ifIdInstr.iFmt.imm16, 2'b00};

	hazardUnit uHazard (
		.CLK         (CLK),
		.rst         (rst),
		.idInstr     (ifIdInstr),
		.exStage     (exStage),
		.memStage    (memStage),
		.branchTaken (branchTaken),
		.jump        (idCtl.jump),
		.hazCtl      (hazCtl)
	);

	always_comb begin
		idNext.valid   = ifIdValid;
		idNext.op      = ifIdInstr.iFmt.op;
		idNext.ctl     = idCtl;
		idNext.rs      = idRs;
		idNext.rt      = idRt;
		idNext.dest    = idDest;
		idNext.pcPlus4 = ifIdPc4;
		idNext.rsVal   = rfA;
		idNext.rtVal   = rfB;
		idNext.imm     = idImm;
		idNext.result  = 32'd0;
	end

	// ID/EX, bubble turns the slot into an invalid no-op
	always_ff @(posedge CLK) begin
		if (rst || hazCtl.bubble) begin
			exStage.valid <= 1'b0;
			exStage.ctl   <= '0;
		end else begin
			exStage <= idNext;
		end
	end

	// EX
	execUnit uExec (
		.exStage    (exStage),
		.memFwd     (memStage),
		.wbFwdValid (rfWe),
		.wbFwdReg   (wbStage.dest),
		.wbFwdData  (wbStage.result),
		.result     (exResult),
		.storeData  (exStoreData)
	);

	// EX/MEM keeps the forwarded store data in rtVal
	always_ff @(posedge CLK) begin
		if (rst) begin
			memStage.valid <= 1'b0;
			memStage.ctl   <= '0;
		end else begin
			memStage        <= exStage;
			memStage.result <= exResult;
			memStage.rtVal  <= exStoreData;
		end
	end

	// MEM
	assign stValid = memStage.valid && memStage.ctl.memWrite;
	assign stAddr  = memStage.result;
	assign stData  = memStage.rtVal;

	dataMem #(
		.DMEM_WORDS (DMEM_WORDS)
	) uDmem (
		.CLK   (CLK),
		.we    (stValid),
		.addr  (memStage.result),
		.wData (memStage.rtVal),
		.rData (memRData)
	);

	// MEM/WB, load data replaces the address
	always_ff @(posedge CLK) begin
		if (rst) begin
			wbStage.valid <= 1'b0;
			wbStage.ctl   <= '0;
		end else begin
			wbStage        <= memStage;
			wbStage.result <= memStage.ctl.memToReg ? memRData : memStage.result;
		end
	end

	// WB, writes to register 0 never retire visibly
	assign rfWe    = wbStage.valid && wbStage.ctl.regWrite && (wbStage.dest != '0);
	assign wbValid = rfWe;
	assign wbReg   = wbStage.dest;
	assign wbData  = wbStage.result;

endmodule

`default_nettype wire

//--- tests/cpuPipe_checker.sv
/*
  interlock properties, bound into hazardUnit
  sampled on the rising clock edge
*/
`default_nettype none

module cpuPipe_checker (
	input wire logic             CLK,
	input wire logic             rst,
	input wire mipsPkg::instrU   idInstr,
	input wire mipsPkg::stageT   exStage,
	input wire mipsPkg::hazCtlT  hazCtl
);

	logic [5:0] idOp;
	logic       readsRs;
	logic       readsRt;
	logic       loadHit;

	// consumer operands decoded here from the raw word
	assign idOp    = idInstr.rFmt.op;
	assign readsRs = idOp inside {mipsPkg::opR, mipsPkg::opAddi,
		mipsPkg::opLw, mipsPkg::opSw};
	assign readsRt = idOp inside {mipsPkg::opR, mipsPkg::opSw};

	// load in EX whose target an ordinary consumer in ID needs
	assign loadHit = exStage.valid && exStage.ctl.memRead && (exStage.dest != '0) &&
		((readsRs && (exStage.dest == idInstr.rFmt.rs)) ||
		(readsRt && (exStage.dest == idInstr.rFmt.rt)));

	// a stall holds the branch, so no redirect in that cycle
	stallNoFlush: assert property (@(posedge CLK) disable iff (rst)
		!(hazCtl.bubble && hazCtl.ifFlush))
		else $error("stall and flush raised together");

	bubbleMatchesHold: assert property (@(posedge CLK) disable iff (rst)
		hazCtl.bubble == !hazCtl.pcWrite)
		else $error("bubble and pcWrite disagree");

	// pipeline is empty while in reset
	quietInReset: assert property (@(posedge CLK)
		rst |-> (hazCtl.pcWrite && hazCtl.ifIdWrite && !hazCtl.bubble && !hazCtl.ifFlush))
		else $error("hazard control active during reset");

	loadUseStalls: assert property (@(posedge CLK) disable iff (rst)
		loadHit |-> (!hazCtl.pcWrite && !hazCtl.ifIdWrite && hazCtl.bubble))
		else $error("load-use hazard without a stall");

endmodule

`default_nettype wire

//--- tests/cpuPipeMonitor.sv
/*
  compares write-back and store pulses with queued expectations
  samples on the falling edge, pulses during reset are ignored
*/
`default_nettype none

module cpuPipeMonitor (
	input wire logic            CLK,
	input wire logic            rst,
	input wire logic            wbValid,
	input wire mipsPkg::regIdxT wbReg,
	input wire logic [31:0]     wbData,
	input wire logic            stValid,
	input wire logic [31:0]     stAddr,
	input wire logic [31:0]     stData
);

	typedef struct packed {
		logic [4:0]  idx;
		logic [31:0] data;
	} wbEntryT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} stEntryT;

	wbEntryT wbQ[$];
	stEntryT stQ[$];
	string   curTest = "none";
	int      mismatchCount = 0;
	int      flowCount = 0;

	task automatic beginTest(input string name);
		curTest = name;
		wbQ.delete();
		stQ.delete();
	endtask

	task automatic expectWb(input logic [4:0] idx, input logic [31:0] data);
		wbQ.push_back('{idx: idx, data: data});
	endtask

	task automatic expectSt(input logic [31:0] addr, input logic [31:0] data);
		stQ.push_back('{addr: addr, data: data});
	endtask

	// anything left over never retired
	task automatic endTest();
		if (wbQ.size() != 0) begin
			flowCount++;
			$display("%s: %0d expected write-backs never happened", curTest, wbQ.size());
		end
		if (stQ.size() != 0) begin
			flowCount++;
			$display("%s: %0d expected stores never happened", curTest, stQ.size());
		end
	endtask

	task automatic checkWb();
		wbEntryT exp;
		if (wbQ.size() == 0) begin
			flowCount++;
			$display("%s: unexpected extra write-back r%0d = %h", curTest, wbReg, wbData);
		end else begin
			exp = wbQ.pop_front();
			if (exp.idx !== wbReg || exp.data !== wbData) begin
				mismatchCount++;
				$display("MISMATCH %s expected r%0d=%h actual r%0d=%h",
					curTest, exp.idx, exp.data, wbReg, wbData);
			end
		end
	endtask

	task automatic checkSt();
		stEntryT exp;
		if (stQ.size() == 0) begin
			flowCount++;
			$display("%s: unexpected extra store [%h] = %h", curTest, stAddr, stData);
		end else begin
			exp = stQ.pop_front();
			if (exp.addr !== stAddr || exp.data !== stData) begin
				mismatchCount++;
				$display("MISMATCH %s expected [%h]=%h actual [%h]=%h",
					curTest, exp.addr, exp.data, stAddr, stData);
			end
		end
	endtask

	always @(negedge CLK) begin
		if (!rst) begin
			if (wbValid) checkWb();
			if (stValid) checkSt();
		end
	end

endmodule

`default_nettype wire

//--- tests/cpuPipeTb.sv
/*
  runs a table of small programs through cpuPipe, one reset per program
  each program ends with a store of zero to the sentinel address 0x3fc
  ROM holds 32 words, unused words are all-zero no-ops
*/
`default_nettype none

module cpuPipeTb;

	localparam int NTESTS = 5;
	localparam int MAXI = 16;
	localparam int MAXE = 10;
	localparam logic [31:0] SENTINEL_ADDR = 32'h3fc;

	typedef struct packed {
		logic [4:0]  idx;
		logic [31:0] data;
	} wbEntryT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} stEntryT;

	logic            CLK;
	logic            rst;
	logic [31:0]     imemAddr;
	logic [31:0]     imemData;
	logic            wbValid;
	mipsPkg::regIdxT wbReg;
	logic [31:0]     wbData;
	logic            stValid;
	logic [31:0]     stAddr;
	logic [31:0]     stData;
	logic [31:0]     rom [32];

	// program table with expected effects
	string       testName [NTESTS];
	logic [31:0] progWord [NTESTS][MAXI];
	int          progLen [NTESTS];
	wbEntryT     expWb [NTESTS][MAXE];
	int          nWb [NTESTS];
	stEntryT     expSt [NTESTS][4];
	int          nSt [NTESTS];
	int          timeoutCount = 0;

	cpuPipe dut (
		.CLK      (CLK),
		.rst      (rst),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData),
		.stValid  (stValid),
		.stAddr   (stAddr),
		.stData   (stData)
	);

	cpuPipeMonitor mon (
		.CLK     (CLK),
		.rst     (rst),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData),
		.stValid (stValid),
		.stAddr  (stAddr),
		.stData  (stData)
	);

	bind hazardUnit cpuPipe_checker hazChk (
		.CLK     (CLK),
		.rst     (rst),
		.idInstr (idInstr),
		.exStage (exStage),
		.hazCtl  (hazCtl)
	);

	// combinational instruction ROM
	assign imemData = rom[imemAddr[6:2]];

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// assemblers
	function automatic logic [31:0] rOp(input logic [5:0] fn, input int rd, rs, rt);
		return {mipsPkg::opR, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] iOp(input logic [5:0] op, input int rt, rs,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jOp(input logic [5:0] op, input int wordIdx);
		return {op, 26'(wordIdx)};
	endfunction

	task automatic emit(input int t, input logic [31:0] word);
		progWord[t][progLen[t]] = word;
		progLen[t]++;
	endtask

	task automatic wantWb(input int t, input int idx, input logic [31:0] data);
		expWb[t][nWb[t]] = '{idx: 5'(idx), data: data};
		nWb[t]++;
	endtask

	task automatic wantSt(input int t, input logic [31:0] addr, input logic [31:0] data);
		expSt[t][nSt[t]] = '{addr: addr, data: data};
		nSt[t]++;
	endtask

	task automatic endWithSentinel(input int t);
		emit(t, iOp(mipsPkg::opSw, 0, 0, SENTINEL_ADDR[15:0]));
		wantSt(t, SENTINEL_ADDR, 32'd0);
	endtask

	task automatic buildTable();
		for (int t = 0; t < NTESTS; t++) begin
			progLen[t] = 0;
			nWb[t] = 0;
			nSt[t] = 0;
		end
		// independent ALU ops, r0 writes stay invisible
		testName[0] = "aluOps";
		emit(0, iOp(mipsPkg::opAddi, 1, 0, 16'd5));
		wantWb(0, 1, 32'd5);
		emit(0, iOp(mipsPkg::opAddi, 2, 0, 16'hfffd));
		wantWb(0, 2, 32'hfffffffd);
		emit(0, iOp(mipsPkg::opAddi, 0, 0, 16'd7));
		emit(0, iOp(mipsPkg::opAddi, 4, 0, 16'd12));
		wantWb(0, 4, 32'd12);
		emit(0, rOp(mipsPkg::fnSub, 5, 1, 2));
		wantWb(0, 5, 32'd8);
		emit(0, rOp(mipsPkg::fnAnd, 6, 4, 1));
		wantWb(0, 6, 32'd4);
		emit(0, rOp(mipsPkg::fnOr, 7, 4, 1));
		wantWb(0, 7, 32'd13);
		emit(0, rOp(mipsPkg::fnSlt, 8, 2, 1));
		wantWb(0, 8, 32'd1);
		emit(0, rOp(mipsPkg::fnSlt, 9, 1, 2));
		wantWb(0, 9, 32'd0);
		emit(0, rOp(mipsPkg::fnAdd, 0, 1, 1));
		endWithSentinel(0);
		// back-to-back dependencies, MEM and WB forwarding
		testName[1] = "fwdChain";
		emit(1, iOp(mipsPkg::opAddi, 1, 0, 16'd3));
		wantWb(1, 1, 32'd3);
		emit(1, rOp(mipsPkg::fnAdd, 2, 1, 1));
		wantWb(1, 2, 32'd6);
		emit(1, rOp(mipsPkg::fnAdd, 3, 2, 1));
		wantWb(1, 3, 32'd9);
		emit(1, rOp(mipsPkg::fnSub, 4, 3, 2));
		wantWb(1, 4, 32'd3);
		emit(1, rOp(mipsPkg::fnOr, 5, 4, 3));
		wantWb(1, 5, 32'd11);
		emit(1, rOp(mipsPkg::fnAdd, 6, 5, 1));
		wantWb(1, 6, 32'd14);
		endWithSentinel(1);
		// load-use stalls, store of a just-loaded value
		testName[2] = "loadUse";
		emit(2, iOp(mipsPkg::opAddi, 1, 0, 16'h40));
		wantWb(2, 1, 32'h40);
		emit(2, iOp(mipsPkg::opAddi, 2, 0, 16'd77));
		wantWb(2, 2, 32'd77);
		emit(2, iOp(mipsPkg::opSw, 2, 1, 16'd0));
		wantSt(2, 32'h40, 32'd77);
		emit(2, iOp(mipsPkg::opLw, 3, 1, 16'd0));
		wantWb(2, 3, 32'd77);
		emit(2, rOp(mipsPkg::fnAdd, 4, 3, 3));
		wantWb(2, 4, 32'd154);
		emit(2, iOp(mipsPkg::opLw, 5, 1, 16'd0));
		wantWb(2, 5, 32'd77);
		emit(2, iOp(mipsPkg::opSw, 5, 1, 16'd4));
		wantSt(2, 32'h44, 32'd77);
		endWithSentinel(2);
		// branches right behind R-format and load producers
		testName[3] = "branchHazards";
		emit(3, iOp(mipsPkg::opAddi, 1, 0, 16'd4));
		wantWb(3, 1, 32'd4);
		emit(3, rOp(mipsPkg::fnAdd, 2, 1, 0));
		wantWb(3, 2, 32'd4);
		emit(3, iOp(mipsPkg::opBeq, 2, 1, 16'd1));
		emit(3, iOp(mipsPkg::opAddi, 9, 0, 16'd99));
		emit(3, iOp(mipsPkg::opSw, 1, 0, 16'h80));
		wantSt(3, 32'h80, 32'd4);
		emit(3, iOp(mipsPkg::opLw, 3, 0, 16'h80));
		wantWb(3, 3, 32'd4);
		emit(3, iOp(mipsPkg::opBne, 1, 3, 16'd1));
		emit(3, iOp(mipsPkg::opAddi, 4, 0, 16'd1));
		wantWb(3, 4, 32'd1);
		emit(3, iOp(mipsPkg::opLw, 5, 0, 16'h80));
		wantWb(3, 5, 32'd4);
		emit(3, iOp(mipsPkg::opAddi, 6, 0, 16'd2));
		wantWb(3, 6, 32'd2);
		emit(3, iOp(mipsPkg::opBeq, 6, 5, 16'd1));
		emit(3, iOp(mipsPkg::opAddi, 7, 0, 16'd3));
		wantWb(3, 7, 32'd3);
		endWithSentinel(3);
		// taken and untaken branches, j and jal, wrong path writes r9
		testName[4] = "jumps";
		emit(4, iOp(mipsPkg::opAddi, 1, 0, 16'd1));
		wantWb(4, 1, 32'd1);
		emit(4, iOp(mipsPkg::opBne, 0, 1, 16'd1));
		emit(4, iOp(mipsPkg::opAddi, 9, 0, 16'd9));
		emit(4, iOp(mipsPkg::opBeq, 0, 1, 16'd1));
		emit(4, iOp(mipsPkg::opAddi, 2, 0, 16'd2));
		wantWb(4, 2, 32'd2);
		emit(4, jOp(mipsPkg::opJ, 7));
		emit(4, iOp(mipsPkg::opAddi, 9, 0, 16'd9));
		emit(4, jOp(mipsPkg::opJal, 10));
		wantWb(4, 31, 32'd32);
		emit(4, iOp(mipsPkg::opAddi, 9, 0, 16'd9));
		emit(4, iOp(mipsPkg::opAddi, 9, 0, 16'd9));
		emit(4, iOp(mipsPkg::opAddi, 3, 31, 16'd0));
		wantWb(4, 3, 32'd32);
		endWithSentinel(4);
	endtask

	task automatic waitSentinel(output bit seen);
		int cycles;
		seen = 1'b0;
		for (cycles = 0; cycles < 200 && !seen; cycles++) begin
			@(negedge CLK);
			if (stValid && stAddr == SENTINEL_ADDR) seen = 1'b1;
		end
	endtask

	task automatic runTest(input int t);
		bit seen;
		@(negedge CLK);
		rst = 1'b1;
		for (int i = 0; i < 32; i++) begin
			rom[i] = (i < progLen[t]) ? progWord[t][i] : 32'd0;
		end
		mon.beginTest(testName[t]);
		for (int i = 0; i < nWb[t]; i++) mon.expectWb(expWb[t][i].idx, expWb[t][i].data);
		for (int i = 0; i < nSt[t]; i++) mon.expectSt(expSt[t][i].addr, expSt[t][i].data);
		repeat (8) @(negedge CLK);
		rst = 1'b0;
		waitSentinel(seen);
		if (!seen) begin
			timeoutCount++;
			$display("%s: timed out waiting for the final sentinel store", testName[t]);
		end
		// let the monitor see the last pulses
		repeat (2) @(negedge CLK);
		mon.endTest();
	endtask

	initial begin
		rst = 1'b1;
		for (int i = 0; i < 32; i++) rom[i] = 32'd0;
		buildTable();
		for (int t = 0; t < NTESTS; t++) runTest(t);
		$display("errors: %0d mismatches, %0d missing or extra pulses, %0d timeouts",
			mon.mismatchCount, mon.flowCount, timeoutCount);
		if (mon.mismatchCount == 0 && mon.flowCount == 0 && timeoutCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpuPipe.f
design/mipsPkg.sv
design/hazardUnit.sv
design/instrDecode.sv
design/regFile.sv
design/execUnit.sv
design/dataMem.sv
design/cpuPipe.sv
tests/cpuPipe_checker.sv
tests/cpuPipeMonitor.sv
tests/cpuPipeTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f cpuPipe.f --top-module cpuPipeTb -o simv
	./obj_dir/simv > sim.log 2>&1; rc=$$?; cat sim.log; test $$rc -eq 0
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log
